// File: Bender.yml
package:
  name: sld_unit

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/sld_pkg.sv
      - hw/sld_sequencer.sv
      - hw/sld_operand_extract.sv
      - hw/sld_byte_shift.sv
      - hw/sld_write_assemble.sv
      - hw/sld_unit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_sld_unit.sv

// File: hw/sld_byte_shift.sv
////////////////////////////////////////////////////////////////////////////
// funnel shift of the chunk pair by the byte offset
////////////////////////////////////////////////////////////////////////////

`include "sld_consts.svh"

module sld_byte_shift (
    input  logic               clk_i,
    input  logic               async_rst_ni,
    input  logic               ext_valid_i,
    input  sld_pkg::chunk_t    ext_low_i,
    input  sld_pkg::chunk_t    ext_high_i,
    input  logic               ext_low_ok_i,
    input  logic               ext_high_ok_i,
    input  sld_pkg::byte_off_t ext_shift_i,
    input  logic               ext_first_i,
    input  sld_pkg::sld_op_e   op_i,
    input  sld_pkg::sew_e      sew_i,
    input  sld_pkg::vl_t       vl_i,
    input  sld_pkg::xval_t     xval_i,
    input  sld_pkg::vaddr_t    vd_i,
    input  sld_pkg::insn_id_t  id_i,
    output logic               sh_valid_o,
    output sld_pkg::chunk_t    sh_data_o,
    output sld_pkg::cmask_t    sh_ok_o,
    output logic               sh_first_o,
    output sld_pkg::sld_op_e   op_o,
    output sld_pkg::sew_e      sew_o,
    output sld_pkg::vl_t       vl_o,
    output sld_pkg::xval_t     xval_o,
    output sld_pkg::vaddr_t    vd_o,
    output sld_pkg::insn_id_t  id_o
);

    logic [2*`SLD_CHUNK_W-1:0] pair;
    sld_pkg::chunk_t           data;
    sld_pkg::cmask_t           ok;

    assign pair = {ext_high_i, ext_low_i};

    always_comb begin
        for (int i = 0; i < `SLD_CHUNK_W/8; i++) begin
            data[i*8 +: 8] = pair[(int'(ext_shift_i) + i)*8 +: 8];
            // a byte keeps the flag of the chunk it came from
            ok[i] = (int'(ext_shift_i) + i < `SLD_CHUNK_W/8) ? ext_low_ok_i : ext_high_ok_i;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            sh_valid_o <= 1'b0;
        end else begin
            sh_valid_o <= ext_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ext_valid_i) begin
            sh_data_o  <= data;
            sh_ok_o    <= ok;
            sh_first_o <= ext_first_i;
            op_o       <= op_i;
            sew_o      <= sew_i;
            vl_o       <= vl_i;
            xval_o     <= xval_i;
            vd_o       <= vd_i;
            id_o       <= id_i;
        end
    end

endmodule

// File: hw/sld_consts.svh
////////////////////////////////////////////////////////////////////////////
// dimensions of the slide unit
// the RTL is written for one 128-bit register split into four 32-bit chunks
////////////////////////////////////////////////////////////////////////////

`ifndef SLD_CONSTS_SVH
`define SLD_CONSTS_SVH

`define SLD_VREG_W  128 // vector register width in bits
`define SLD_CHUNK_W 32  // datapath chunk width
`define SLD_CHUNKS  4   // chunks per register
`define SLD_ID_W    3   // instruction id width
`define SLD_VL_W    5   // element count, vl runs 0 to 16

`endif

// File: hw/sld_operand_extract.sv
////////////////////////////////////////////////////////////////////////////
// picks the source chunk pair for each step
// chunks outside the register read as zero
////////////////////////////////////////////////////////////////////////////

`include "sld_consts.svh"

module sld_operand_extract (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  logic                seq_valid_i,
    input  sld_pkg::vreg_t      seq_src_i,
    input  sld_pkg::chunk_idx_t seq_chunk_i,
    input  sld_pkg::byte_off_t  seq_shift_i,
    input  logic                seq_first_i,
    input  logic                seq_overflow_i,
    input  sld_pkg::sld_op_e    op_i,
    input  sld_pkg::sew_e       sew_i,
    input  sld_pkg::vl_t        vl_i,
    input  sld_pkg::xval_t      xval_i,
    input  sld_pkg::vaddr_t     vd_i,
    input  sld_pkg::insn_id_t   id_i,
    output logic                ext_valid_o,
    output sld_pkg::chunk_t     ext_low_o,
    output sld_pkg::chunk_t     ext_high_o,
    output logic                ext_low_ok_o,
    output logic                ext_high_ok_o,
    output sld_pkg::byte_off_t  ext_shift_o,
    output logic                ext_first_o,
    output sld_pkg::sld_op_e    op_o,
    output sld_pkg::sew_e       sew_o,
    output sld_pkg::vl_t        vl_o,
    output sld_pkg::xval_t      xval_o,
    output sld_pkg::vaddr_t     vd_o,
    output sld_pkg::insn_id_t   id_o
);

    sld_pkg::chunk_idx_t high_idx;
    sld_pkg::chunk_t     low, high;
    logic                low_ok, high_ok;
    logic                pad_ok; // whether zeros from outside the register get written

    assign high_idx = seq_chunk_i + 4'sd1;
    assign pad_ok   = (op_i == sld_pkg::SLD_DOWN) | (op_i == sld_pkg::SLD_1DOWN);

    always_comb begin
        low     = '0;
        high    = '0;
        low_ok  = pad_ok;
        high_ok = pad_ok;
        if (!seq_overflow_i) begin
            if (seq_chunk_i >= 0 && seq_chunk_i < `SLD_CHUNKS) begin
                low    = seq_src_i[seq_chunk_i[1:0]*`SLD_CHUNK_W +: `SLD_CHUNK_W];
                low_ok = 1'b1;
            end
            if (high_idx >= 0 && high_idx < `SLD_CHUNKS) begin
                high    = seq_src_i[high_idx[1:0]*`SLD_CHUNK_W +: `SLD_CHUNK_W];
                high_ok = 1'b1;
            end
        end
        // slide1up feeds the scalar in as element -1
        if (seq_first_i && op_i == sld_pkg::SLD_1UP) begin
            case (sew_i)
                sld_pkg::SEW_8:  low[31:24] = xval_i[7:0];
                sld_pkg::SEW_16: low[31:16] = xval_i[15:0];
                default:         low        = xval_i;
            endcase
            low_ok = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            ext_valid_o <= 1'b0;
        end else begin
            ext_valid_o <= seq_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (seq_valid_i) begin
            ext_low_o     <= low;
            ext_high_o    <= high;
            ext_low_ok_o  <= low_ok;
            ext_high_ok_o <= high_ok;
            ext_shift_o   <= seq_shift_i;
            ext_first_o   <= seq_first_i;
            op_o          <= op_i;
            sew_o         <= sew_i;
            vl_o          <= vl_i;
            xval_o        <= xval_i;
            vd_o          <= vd_i;
            id_o          <= id_i;
        end
    end

endmodule

// File: hw/sld_pkg.sv
////////////////////////////////////////////////////////////////////////////
// types shared by the stages of the slide unit
////////////////////////////////////////////////////////////////////////////

`include "sld_consts.svh"

package sld_pkg;

    typedef logic [`SLD_VREG_W-1:0]            vreg_t;
    typedef logic [`SLD_VREG_W/8-1:0]          vmask_t;   // one bit per register byte
    typedef logic [`SLD_CHUNK_W-1:0]           chunk_t;
    typedef logic [`SLD_CHUNK_W/8-1:0]         cmask_t;   // one bit per chunk byte
    typedef logic [$clog2(`SLD_CHUNK_W/8)-1:0] byte_off_t;
    typedef logic signed [3:0]                 chunk_idx_t; // goes negative for slide up
    typedef logic [4:0]                        vaddr_t;
    typedef logic [`SLD_ID_W-1:0]              insn_id_t;
    typedef logic [`SLD_VL_W-1:0]              vl_t;
    typedef logic [31:0]                       xval_t;

    // element width
    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32
    } sew_e;

    typedef enum logic [1:0] {
        SLD_UP,
        SLD_DOWN,
        SLD_1UP,
        SLD_1DOWN
    } sld_op_e;

    typedef enum logic {
        IDLE,
        RUN
    } seq_state_e;

endpackage

// File: hw/sld_sequencer.sv
////////////////////////////////////////////////////////////////////////////
// takes one instruction every 4 cycles and reads vs2 in the first step
// the host holds its fields stable until op_ack_o
////////////////////////////////////////////////////////////////////////////

`include "sld_consts.svh"

module sld_sequencer (
    input  logic                clk_i,
    input  logic                async_rst_ni,
    input  logic                op_rdy_i,
    output logic                op_ack_o,
    input  sld_pkg::sld_op_e    op_i,
    input  sld_pkg::sew_e       sew_i,
    input  sld_pkg::vl_t        vl_i,
    input  sld_pkg::xval_t      xval_i,
    input  sld_pkg::vaddr_t     vs2_i,
    input  sld_pkg::vaddr_t     vd_i,
    input  sld_pkg::insn_id_t   id_i,
    output sld_pkg::vaddr_t     vreg_rd_addr_o,
    input  sld_pkg::vreg_t      vreg_rd_i,
    output logic                seq_valid_o,
    output sld_pkg::vreg_t      seq_src_o,
    output sld_pkg::chunk_idx_t seq_chunk_o,
    output sld_pkg::byte_off_t  seq_shift_o,
    output logic                seq_first_o,
    output logic                seq_overflow_o,
    output sld_pkg::sld_op_e    op_o,
    output sld_pkg::sew_e       sew_o,
    output sld_pkg::vl_t        vl_o,
    output sld_pkg::xval_t      xval_o,
    output sld_pkg::vaddr_t     vd_o,
    output sld_pkg::insn_id_t   id_o
);

    sld_pkg::seq_state_e state_q;
    logic [1:0]          step_q;
    logic                last_step;

    // instruction held for the four steps
    sld_pkg::sld_op_e    op_q;
    sld_pkg::sew_e       sew_q;
    sld_pkg::vl_t        vl_q;
    sld_pkg::xval_t      xval_q;
    sld_pkg::vaddr_t     vs2_q, vd_q;
    sld_pkg::insn_id_t   id_q;
    sld_pkg::chunk_idx_t start_chunk, start_chunk_q;
    sld_pkg::byte_off_t  start_off, start_off_q;
    logic                ovf_q;

    logic [3:0] byte_slide; // slide distance in bytes
    logic       overflow;   // distance reaches past the register

    assign last_step      = step_q == 2'(`SLD_CHUNKS - 1);
    assign op_ack_o       = op_rdy_i & ((state_q == sld_pkg::IDLE) | last_step);
    assign vreg_rd_addr_o = vs2_q; // sampled in step 0

    ////////////////////////////////////////////////////////////////////////////
    // slide distance

    always_comb begin
        byte_slide = 4'd0;
        overflow   = 1'b0;
        if (op_i == sld_pkg::SLD_UP || op_i == sld_pkg::SLD_DOWN) begin
            case (sew_i)
                sld_pkg::SEW_8: begin
                    byte_slide = xval_i[3:0];
                    overflow   = |xval_i[31:4];
                end
                sld_pkg::SEW_16: begin
                    byte_slide = {xval_i[2:0], 1'b0};
                    overflow   = |xval_i[31:3];
                end
                default: begin
                    byte_slide = {xval_i[1:0], 2'b00};
                    overflow   = |xval_i[31:2];
                end
            endcase
        end else begin
            case (sew_i) // slide1 moves by one element
                sld_pkg::SEW_8:  byte_slide = 4'd1;
                sld_pkg::SEW_16: byte_slide = 4'd2;
                default:         byte_slide = 4'd4;
            endcase
        end
    end

    // split into starting chunk and byte offset inside the chunk pair
    always_comb begin
        if (op_i == sld_pkg::SLD_UP || op_i == sld_pkg::SLD_1UP) begin
            start_chunk = -$signed({2'b00, byte_slide[3:2]})
                          - $signed({3'b000, |byte_slide[1:0]});
            start_off   = -byte_slide[1:0];
        end else begin
            start_chunk = $signed({2'b00, byte_slide[3:2]});
            start_off   = byte_slide[1:0];
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // step FSM

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            state_q <= sld_pkg::IDLE;
            step_q  <= '0;
        end else if (op_ack_o) begin
            state_q <= sld_pkg::RUN;
            step_q  <= '0;
        end else if (state_q == sld_pkg::RUN) begin
            step_q <= step_q + 2'd1;
            if (last_step) begin
                state_q <= sld_pkg::IDLE;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            op_q          <= op_i;
            sew_q         <= sew_i;
            vl_q          <= vl_i;
            xval_q        <= xval_i;
            vs2_q         <= vs2_i;
            vd_q          <= vd_i;
            id_q          <= id_i;
            start_chunk_q <= start_chunk;
            start_off_q   <= start_off;
            ovf_q         <= overflow;
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            seq_valid_o <= 1'b0;
        end else begin
            seq_valid_o <= state_q == sld_pkg::RUN;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == sld_pkg::RUN) begin
            if (step_q == 2'd0) begin
                seq_src_o <= vreg_rd_i; // source stays put for the remaining steps
            end
            seq_chunk_o    <= start_chunk_q + $signed({2'b00, step_q});
            seq_shift_o    <= start_off_q;
            seq_first_o    <= step_q == 2'd0;
            seq_overflow_o <= ovf_q;
            op_o           <= op_q;
            sew_o          <= sew_q;
            vl_o           <= vl_q;
            xval_o         <= xval_q;
            vd_o           <= vd_q;
            id_o           <= id_q;
        end
    end

endmodule

// File: hw/sld_unit.sv
////////////////////////////////////////////////////////////////////////////
// slide unit top
// write and done follow the accepting edge by 8 cycles without back-pressure
////////////////////////////////////////////////////////////////////////////

module sld_unit (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    input  logic              op_rdy_i,
    output logic              op_ack_o,
    input  sld_pkg::sld_op_e  op_i,
    input  sld_pkg::sew_e     sew_i,
    input  sld_pkg::vl_t      vl_i,
    input  sld_pkg::xval_t    xval_i,
    input  sld_pkg::vaddr_t   vs2_i,
    input  sld_pkg::vaddr_t   vd_i,
    input  sld_pkg::insn_id_t id_i,
    output sld_pkg::vaddr_t   vreg_rd_addr_o,
    input  sld_pkg::vreg_t    vreg_rd_i,
    output logic              vreg_wr_en_o,
    output sld_pkg::vaddr_t   vreg_wr_addr_o,
    output sld_pkg::vreg_t    vreg_wr_o,
    output sld_pkg::vmask_t   vreg_wr_mask_o,
    output logic              instr_done_valid_o,
    output sld_pkg::insn_id_t instr_done_id_o
);

    // sequencer to extract
    logic                seq_valid, seq_first, seq_overflow;
    sld_pkg::vreg_t      seq_src;
    sld_pkg::chunk_idx_t seq_chunk;
    sld_pkg::byte_off_t  seq_shift, ext_shift;

    // extract to shift to assemble
    logic                ext_valid, ext_low_ok, ext_high_ok, ext_first;
    sld_pkg::chunk_t     ext_low, ext_high, sh_data;
    logic                sh_valid, sh_first;
    sld_pkg::cmask_t     sh_ok;

    // control that travels with every chunk
    sld_pkg::sld_op_e    seq_op, ext_op, sh_op;
    sld_pkg::sew_e       seq_sew, ext_sew, sh_sew;
    sld_pkg::vl_t        seq_vl, ext_vl, sh_vl;
    sld_pkg::xval_t      seq_xval, ext_xval, sh_xval;
    sld_pkg::vaddr_t     seq_vd, ext_vd, sh_vd;
    sld_pkg::insn_id_t   seq_id, ext_id, sh_id;

    sld_sequencer i_sequencer (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .vl_i           (vl_i),
        .xval_i         (xval_i),
        .vs2_i          (vs2_i),
        .vd_i           (vd_i),
        .id_i           (id_i),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_rd_i      (vreg_rd_i),
        .seq_valid_o    (seq_valid),
        .seq_src_o      (seq_src),
        .seq_chunk_o    (seq_chunk),
        .seq_shift_o    (seq_shift),
        .seq_first_o    (seq_first),
        .seq_overflow_o (seq_overflow),
        .op_o           (seq_op),
        .sew_o          (seq_sew),
        .vl_o           (seq_vl),
        .xval_o         (seq_xval),
        .vd_o           (seq_vd),
        .id_o           (seq_id)
    );

    sld_operand_extract i_extract (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .seq_valid_i    (seq_valid),
        .seq_src_i      (seq_src),
        .seq_chunk_i    (seq_chunk),
        .seq_shift_i    (seq_shift),
        .seq_first_i    (seq_first),
        .seq_overflow_i (seq_overflow),
        .op_i           (seq_op),
        .sew_i          (seq_sew),
        .vl_i           (seq_vl),
        .xval_i         (seq_xval),
        .vd_i           (seq_vd),
        .id_i           (seq_id),
        .ext_valid_o    (ext_valid),
        .ext_low_o      (ext_low),
        .ext_high_o     (ext_high),
        .ext_low_ok_o   (ext_low_ok),
        .ext_high_ok_o  (ext_high_ok),
        .ext_shift_o    (ext_shift),
        .ext_first_o    (ext_first),
        .op_o           (ext_op),
        .sew_o          (ext_sew),
        .vl_o           (ext_vl),
        .xval_o         (ext_xval),
        .vd_o           (ext_vd),
        .id_o           (ext_id)
    );

    sld_byte_shift i_shift (
        .clk_i         (clk_i),
        .async_rst_ni  (async_rst_ni),
        .ext_valid_i   (ext_valid),
        .ext_low_i     (ext_low),
        .ext_high_i    (ext_high),
        .ext_low_ok_i  (ext_low_ok),
        .ext_high_ok_i (ext_high_ok),
        .ext_shift_i   (ext_shift),
        .ext_first_i   (ext_first),
        .op_i          (ext_op),
        .sew_i         (ext_sew),
        .vl_i          (ext_vl),
        .xval_i        (ext_xval),
        .vd_i          (ext_vd),
        .id_i          (ext_id),
        .sh_valid_o    (sh_valid),
        .sh_data_o     (sh_data),
        .sh_ok_o       (sh_ok),
        .sh_first_o    (sh_first),
        .op_o          (sh_op),
        .sew_o         (sh_sew),
        .vl_o          (sh_vl),
        .xval_o        (sh_xval),
        .vd_o          (sh_vd),
        .id_o          (sh_id)
    );

    sld_write_assemble i_assemble (
        .clk_i              (clk_i),
        .async_rst_ni       (async_rst_ni),
        .sh_valid_i         (sh_valid),
        .sh_data_i          (sh_data),
        .sh_ok_i            (sh_ok),
        .sh_first_i         (sh_first),
        .op_i               (sh_op),
        .sew_i              (sh_sew),
        .vl_i               (sh_vl),
        .xval_i             (sh_xval),
        .vd_i               (sh_vd),
        .id_i               (sh_id),
        .vreg_wr_en_o       (vreg_wr_en_o),
        .vreg_wr_addr_o     (vreg_wr_addr_o),
        .vreg_wr_o          (vreg_wr_o),
        .vreg_wr_mask_o     (vreg_wr_mask_o),
        .instr_done_valid_o (instr_done_valid_o),
        .instr_done_id_o    (instr_done_id_o)
    );

endmodule

// File: hw/sld_write_assemble.sv
////////////////////////////////////////////////////////////////////////////
// gathers four result chunks and issues one masked register write
// vl is assumed not to exceed the element count of the register
////////////////////////////////////////////////////////////////////////////

`include "sld_consts.svh"

module sld_write_assemble (
    input  logic              clk_i,
    input  logic              async_rst_ni,
    input  logic              sh_valid_i,
    input  sld_pkg::chunk_t   sh_data_i,
    input  sld_pkg::cmask_t   sh_ok_i,
    input  logic              sh_first_i,
    input  sld_pkg::sld_op_e  op_i,
    input  sld_pkg::sew_e     sew_i,
    input  sld_pkg::vl_t      vl_i,
    input  sld_pkg::xval_t    xval_i,
    input  sld_pkg::vaddr_t   vd_i,
    input  sld_pkg::insn_id_t id_i,
    output logic              vreg_wr_en_o,
    output sld_pkg::vaddr_t   vreg_wr_addr_o,
    output sld_pkg::vreg_t    vreg_wr_o,
    output sld_pkg::vmask_t   vreg_wr_mask_o,
    output logic              instr_done_valid_o,
    output sld_pkg::insn_id_t instr_done_id_o
);

    logic [1:0]        cnt_q, idx;
    logic              full_q;  // all four chunks collected
    sld_pkg::vreg_t    data_q, wr_data;
    sld_pkg::vmask_t   flags_q, vl_mask;
    sld_pkg::sld_op_e  op_q;
    sld_pkg::sew_e     sew_q;
    sld_pkg::vl_t      vl_q;
    sld_pkg::xval_t    xval_q;
    sld_pkg::vaddr_t   vd_q;
    sld_pkg::insn_id_t id_q;
    logic [3:0]        last_elem;

    assign idx       = sh_first_i ? 2'd0 : cnt_q;
    assign last_elem = 4'(vl_q - 5'd1);

    ////////////////////////////////////////////////////////////////////////////
    // chunk collection

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            cnt_q  <= '0;
            full_q <= 1'b0;
        end else begin
            full_q <= sh_valid_i & (idx == 2'(`SLD_CHUNKS - 1));
            if (sh_valid_i) begin
                cnt_q <= idx + 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (sh_valid_i) begin
            data_q  <= {sh_data_i, data_q[`SLD_VREG_W-1:`SLD_CHUNK_W]}; // chunk 0 ends up lowest
            flags_q <= {sh_ok_i, flags_q[`SLD_VREG_W/8-1:`SLD_CHUNK_W/8]};
            op_q    <= op_i;
            sew_q   <= sew_i;
            vl_q    <= vl_i;
            xval_q  <= xval_i;
            vd_q    <= vd_i;
            id_q    <= id_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // write build

    always_comb begin
        for (int j = 0; j < `SLD_VREG_W/8; j++) begin
            vl_mask[j] = (j >> sew_q) < vl_q; // byte belongs to an element below vl
        end
        wr_data = data_q;
        if (op_q == sld_pkg::SLD_1DOWN && vl_q != '0) begin
            case (sew_q)
                sld_pkg::SEW_8:  wr_data[last_elem*8 +: 8]        = xval_q[7:0];
                sld_pkg::SEW_16: wr_data[last_elem[2:0]*16 +: 16] = xval_q[15:0];
                default:         wr_data[last_elem[1:0]*32 +: 32] = xval_q;
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            vreg_wr_en_o <= 1'b0;
        end else begin
            vreg_wr_en_o <= full_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (full_q) begin
            vreg_wr_o       <= wr_data;
            vreg_wr_mask_o  <= flags_q & vl_mask;
            vreg_wr_addr_o  <= vd_q;
            instr_done_id_o <= id_q;
        end
    end

    assign instr_done_valid_o = vreg_wr_en_o; // done goes out with the write

endmodule

// File: sources.f
+incdir+hw
+incdir+tb
hw/sld_pkg.sv
hw/sld_sequencer.sv
hw/sld_operand_extract.sv
hw/sld_byte_shift.sv
hw/sld_write_assemble.sv
hw/sld_unit.sv
tb/tb_sld_unit.sv

// File: tb/sld_vectors.svh
////////////////////////////////////////////////////////////////////////////
// stimulus and expected writes for the slide unit testbench
// source register r holds byte value r*16+b in byte b
////////////////////////////////////////////////////////////////////////////

`ifndef SLD_VECTORS_SVH
`define SLD_VECTORS_SVH

// columns: op, sew, vl, xval, vs2, vd, id, expected data, expected byte mask
// xval is the amount for slide up/down and the scalar for slide1
// unwritten bytes hold zero in the expected data
task automatic load_rows();
    // slide up by 3 bytes
    add_row(sld_pkg::SLD_UP, sld_pkg::SEW_8, 5'd16, 32'd3, 5'd2, 5'd10, 3'd0,
            128'h2C2B2A29_28272625_24232221_20000000, 16'hFFF8);
    add_row(sld_pkg::SLD_UP, sld_pkg::SEW_32, 5'd4, 32'd2, 5'd3, 5'd11, 3'd1,
            128'h37363534_33323130_00000000_00000000, 16'hFF00);
    // slide down past the end pads with zeros
    add_row(sld_pkg::SLD_DOWN, sld_pkg::SEW_16, 5'd8, 32'd5, 5'd4, 5'd12, 3'd2,
            128'h00000000_00000000_00004F4E_4D4C4B4A, 16'hFFFF);

    // slide1up, scalar enters element 0
    add_row(sld_pkg::SLD_1UP, sld_pkg::SEW_8, 5'd16, 32'h1234_56A5, 5'd5, 5'd13, 3'd3,
            128'h5E5D5C5B_5A595857_56555453_525150A5, 16'hFFFF);
    add_row(sld_pkg::SLD_1UP, sld_pkg::SEW_16, 5'd8, 32'h0000_BEEF, 5'd6, 5'd14, 3'd4,
            128'h6D6C6B6A_69686766_65646362_6160BEEF, 16'hFFFF);
    add_row(sld_pkg::SLD_1UP, sld_pkg::SEW_32, 5'd3, 32'h89AB_CDEF, 5'd7, 5'd15, 3'd5,
            128'h00000000_77767574_73727170_89ABCDEF, 16'h0FFF);

    // slide1down, scalar lands in element vl-1
    add_row(sld_pkg::SLD_1DOWN, sld_pkg::SEW_8, 5'd5, 32'h0000_005A, 5'd8, 5'd16, 3'd6,
            128'h00000000_00000000_0000005A_84838281, 16'h001F);
    add_row(sld_pkg::SLD_1DOWN, sld_pkg::SEW_16, 5'd8, 32'h0000_1357, 5'd9, 5'd17, 3'd7,
            128'h13579F9E_9D9C9B9A_99989796_95949392, 16'hFFFF);
    add_row(sld_pkg::SLD_1DOWN, sld_pkg::SEW_32, 5'd2, 32'h2468_ACE0, 5'd10, 5'd18, 3'd0,
            128'h00000000_00000000_2468ACE0_A7A6A5A4, 16'h00FF);

    // byte offset of exactly 16 overflows
    add_row(sld_pkg::SLD_UP, sld_pkg::SEW_8, 5'd16, 32'd16, 5'd11, 5'd19, 3'd1,
            128'h0, 16'h0000);
    add_row(sld_pkg::SLD_DOWN, sld_pkg::SEW_32, 5'd3, 32'd4, 5'd12, 5'd20, 3'd2,
            128'h0, 16'h0FFF);
    // vl 0 writes nothing
    add_row(sld_pkg::SLD_1DOWN, sld_pkg::SEW_8, 5'd0, 32'h0000_0011, 5'd13, 5'd21, 3'd3,
            128'h0, 16'h0000);

    // slide up at 16 bits with a partial vl
    add_row(sld_pkg::SLD_UP, sld_pkg::SEW_16, 5'd7, 32'd3, 5'd14, 5'd22, 3'd4,
            128'h0000E7E6_E5E4E3E2_E1E00000_00000000, 16'h3FC0);
    add_row(sld_pkg::SLD_DOWN, sld_pkg::SEW_32, 5'd4, 32'd1, 5'd15, 5'd23, 3'd5,
            128'h00000000_FFFEFDFC_FBFAF9F8_F7F6F5F4, 16'hFFFF);
endtask

`endif

// File: tb/tb_sld_unit.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the slide unit with rows sent back to back
// the register file model answers reads at once and ignores writes
////////////////////////////////////////////////////////////////////////////

module tb_sld_unit;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD    = 20;
    localparam int RESET_CYCLES  = 5;
    localparam int WRITE_LATENCY = 8; // accepting edge to write pulse

    typedef struct {
        sld_pkg::sld_op_e  op;
        sld_pkg::sew_e     sew;
        sld_pkg::vl_t      vl;
        sld_pkg::xval_t    xval;
        sld_pkg::vaddr_t   vs2;
        sld_pkg::vaddr_t   vd;
        sld_pkg::insn_id_t id;
        sld_pkg::vreg_t    data;
        sld_pkg::vmask_t   mask;
    } row_t;

    logic              clk_i;
    logic              async_rst_ni;
    logic              op_rdy_i, op_ack_o;
    sld_pkg::sld_op_e  op_i;
    sld_pkg::sew_e     sew_i;
    sld_pkg::vl_t      vl_i;
    sld_pkg::xval_t    xval_i;
    sld_pkg::vaddr_t   vs2_i, vd_i, vreg_rd_addr_o, vreg_wr_addr_o;
    sld_pkg::insn_id_t id_i, instr_done_id_o;
    sld_pkg::vreg_t    vreg_rd_i, vreg_wr_o;
    sld_pkg::vmask_t   vreg_wr_mask_o;
    logic              vreg_wr_en_o, instr_done_valid_o;

    row_t rows[$];
    time  accept_times[$]; // accepting edge of each row in order

    sld_unit uut (
        .clk_i              (clk_i),
        .async_rst_ni       (async_rst_ni),
        .op_rdy_i           (op_rdy_i),
        .op_ack_o           (op_ack_o),
        .op_i               (op_i),
        .sew_i              (sew_i),
        .vl_i               (vl_i),
        .xval_i             (xval_i),
        .vs2_i              (vs2_i),
        .vd_i               (vd_i),
        .id_i               (id_i),
        .vreg_rd_addr_o     (vreg_rd_addr_o),
        .vreg_rd_i          (vreg_rd_i),
        .vreg_wr_en_o       (vreg_wr_en_o),
        .vreg_wr_addr_o     (vreg_wr_addr_o),
        .vreg_wr_o          (vreg_wr_o),
        .vreg_wr_mask_o     (vreg_wr_mask_o),
        .instr_done_valid_o (instr_done_valid_o),
        .instr_done_id_o    (instr_done_id_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // byte b of register r holds r*16+b and the upper sixteen registers hold it inverted
    function automatic sld_pkg::vreg_t reg_contents(input sld_pkg::vaddr_t r);
        sld_pkg::vreg_t v;
        for (int b = 0; b < 16; b++) begin
            v[b*8 +: 8] = 8'(r * 16 + b) ^ {8{r[4]}};
        end
        return v;
    endfunction

    assign vreg_rd_i = reg_contents(vreg_rd_addr_o);

    function automatic sld_pkg::vreg_t expand_byte_mask(input sld_pkg::vmask_t m);
        sld_pkg::vreg_t bits;
        for (int b = 0; b < 16; b++) begin
            bits[b*8 +: 8] = {8{m[b]}};
        end
        return bits;
    endfunction

    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        if (got !== exp) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
            $display("sim failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic add_row(input sld_pkg::sld_op_e op, input sld_pkg::sew_e sew,
                           input sld_pkg::vl_t vl, input sld_pkg::xval_t xval,
                           input sld_pkg::vaddr_t vs2, input sld_pkg::vaddr_t vd,
                           input sld_pkg::insn_id_t id, input sld_pkg::vreg_t data,
                           input sld_pkg::vmask_t mask);
        row_t row;
        row.op   = op;
        row.sew  = sew;
        row.vl   = vl;
        row.xval = xval;
        row.vs2  = vs2;
        row.vd   = vd;
        row.id   = id;
        row.data = data;
        row.mask = mask;
        rows.push_back(row);
    endtask

    `include "sld_vectors.svh"

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic send_row(input int i);
        logic accepted;
        accepted = 1'b0;
        op_rdy_i = 1'b1;
        op_i     = rows[i].op;
        sew_i    = rows[i].sew;
        vl_i     = rows[i].vl;
        xval_i   = rows[i].xval;
        vs2_i    = rows[i].vs2;
        vd_i     = rows[i].vd;
        id_i     = rows[i].id;
        while (!accepted) begin
            #(CLK_PERIOD/4);
            accepted = op_ack_o; // settled well before the rising edge
            @(posedge clk_i);
            if (accepted) begin
                accept_times.push_back($time);
            end
            @(negedge clk_i);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reset and stimulus

    initial begin : stimulus
        clk_i        = 1'b0;
        async_rst_ni = 1'b0;
        op_rdy_i     = 1'b0;
        op_i         = sld_pkg::SLD_UP;
        sew_i        = sld_pkg::SEW_8;
        vl_i         = '0;
        xval_i       = '0;
        vs2_i        = '0;
        vd_i         = '0;
        id_i         = '0;
        load_rows();
        repeat (RESET_CYCLES) @(negedge clk_i);
        async_rst_ni = 1'b1;
        @(negedge clk_i);
        compare_value("op_ack_o", op_ack_o, 1'b0); // idle with no request
        compare_value("vreg_wr_en_o", vreg_wr_en_o, 1'b0);
        compare_value("instr_done_valid_o", instr_done_valid_o, 1'b0);
        for (int i = 0; i < rows.size(); i++) begin
            send_row(i);
        end
        op_rdy_i = 1'b0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // write monitor

    initial begin : monitor
        int             checked;
        time            accepted_at;
        sld_pkg::vreg_t byte_bits;
        checked = 0;
        @(posedge async_rst_ni);
        while (checked < rows.size()) begin
            @(negedge clk_i);
            if (vreg_wr_en_o || instr_done_valid_o) begin
                if (accept_times.size() == 0) begin
                    $display("a write came out at %0d ns before any row was accepted", $time);
                    $display("sim failed");
                    $fatal(1, "write without an instruction");
                end
                accepted_at = accept_times.pop_front();
                byte_bits   = expand_byte_mask(rows[checked].mask);
                compare_value("vreg_wr_en_o", vreg_wr_en_o, 1'b1);
                compare_value("instr_done_valid_o", instr_done_valid_o, 1'b1);
                compare_value("instr_done_id_o", instr_done_id_o, rows[checked].id);
                compare_value("vreg_wr_addr_o", vreg_wr_addr_o, rows[checked].vd);
                compare_value("vreg_wr_mask_o", vreg_wr_mask_o, rows[checked].mask);
                compare_value("vreg_wr_o", vreg_wr_o & byte_bits, rows[checked].data);
                compare_value("write latency", ($time - accepted_at - CLK_PERIOD/2) / CLK_PERIOD,
                              WRITE_LATENCY);
                checked++;
            end
        end
        repeat (2 * WRITE_LATENCY) begin // nothing more may come out
            @(negedge clk_i);
            compare_value("vreg_wr_en_o", vreg_wr_en_o, 1'b0);
        end
        $display("sim passed");
        $finish;
    end

    initial begin : watchdog
        @(posedge async_rst_ni);
        #((rows.size() * 12 + 100) * CLK_PERIOD);
        $display("timeout: not every row produced its write in time");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

endmodule
